// File: tb.f
+incdir+design
design/throttle_pkg.sv
design/trigger_sync.sv
design/clock_gate.sv
design/throttle_core.sv
design/throttle_cfg_regs.sv
design/throttle_top.sv
bench/throttle_tb.sv

// File: Makefile
# Verilator build and run for the clock throttle testbench

SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := throttle_tb
RTL_TOP  := throttle_top
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := No errors

.PHONY: all build run lint clean

# Build and run
all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/throttle_tb.sv
// Clock throttle testbench
// Table of configuration writes, each followed by clk_out pulse counts per window

`timescale 1ns/1ps
`default_nettype none

`include "throttle_defs.svh"

module throttle_tb
  import throttle_pkg::*;
();

  // ------------------------------------------------------------
  // Constants and types
  // ------------------------------------------------------------

  localparam int CLK_HALF    = 10;
  localparam int RST_CYCLES  = 10;
  localparam int SETTLE      = 4;
  // One full counter period
  localparam int WINDOW      = 1 << `THR_CNTR_WIDTH;
  localparam int ACK_TIMEOUT = 20;
  localparam int NUM_ROWS    = 10;
  localparam int MAX_GAP     = 5;

  // One stimulus row with its expected pulse count
  typedef struct packed {
    logic                       enable;
    logic [`THR_CNTR_WIDTH-1:0] skip;
    logic                       trigger;
    logic [3:0]                 windows;
    logic [3:0]                 expected;
  } row_t;

  // DUT ports
  logic          clk_in;
  logic          rst;
  logic          trigger;
  logic          cfg_req;
  throttle_cfg_t cfg_data;
  logic          cfg_ack;
  logic          clk_out;

  row_t          rows [NUM_ROWS];
  // Free-running count of gated clock edges
  int unsigned   pulse_cnt = 0;
  int unsigned   gap;
  throttle_cfg_t wr_cfg;

  throttle_top throttle_top_inst (
    .clk_in  (clk_in),
    .rst     (rst),
    .trigger (trigger),
    .cfg_req (cfg_req),
    .cfg_data(cfg_data),
    .cfg_ack (cfg_ack),
    .clk_out (clk_out)
  );

  // 20 ns input clock
  initial begin
    clk_in = 1'b0;
    forever #CLK_HALF clk_in = ~clk_in;
  end

  // Counter clocked by the gated clock, read only in the low phase of clk_in
  always @(posedge clk_out) begin
    pulse_cnt <= pulse_cnt + 1;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("Fail %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
    end
  endtask

  function automatic row_t make_row(input int enable, input int skip, input int trig,
                                    input int windows, input int expected);
    row_t r;
    r.enable   = enable[0];
    r.skip     = skip[`THR_CNTR_WIDTH-1:0];
    r.trigger  = trig[0];
    r.windows  = windows[3:0];
    r.expected = expected[3:0];
    return r;
  endfunction

  // Expected count is 8 minus skip only with enable and trigger both high
  task automatic load_table();
    // Throttling with trigger high, skip 0, 1, 3, 5, 7
    rows[0] = make_row(1, 0, 1, 4, 8);
    rows[1] = make_row(1, 1, 1, 4, 7);
    rows[2] = make_row(1, 3, 1, 8, 5);
    rows[3] = make_row(1, 5, 1, 4, 3);
    rows[4] = make_row(1, 7, 1, 8, 1);
    // Trigger low passes everything
    rows[5] = make_row(1, 4, 0, 4, 8);
    rows[6] = make_row(1, 7, 0, 4, 8);
    // Throttling off
    rows[7] = make_row(0, 6, 1, 4, 8);
    // Back to back, skip 2 then 6, trigger stays high
    rows[8] = make_row(1, 2, 1, 4, 6);
    rows[9] = make_row(1, 6, 1, 8, 2);
  endtask

  // Four-phase write, both phases polled in the low clock phase
  task automatic write_cfg(input throttle_cfg_t data);
    int cycles;
    @(posedge clk_in);
    cfg_data <= data;
    cfg_req  <= 1'b1;
    cycles = 0;
    do begin
      @(negedge clk_in);
      cycles++;
    end while (!cfg_ack && cycles < ACK_TIMEOUT);
    if (!cfg_ack) begin
      report_failure("cfg_ack did not rise within the timeout after cfg_req went high");
    end
    // Held settings go out on the ack edge
    check_value("cfg", throttle_top_inst.cfg, data);
    @(posedge clk_in);
    cfg_req <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_in);
      cycles++;
    end while (cfg_ack && cycles < ACK_TIMEOUT);
    if (cfg_ack) begin
      report_failure("cfg_ack did not fall within the timeout after cfg_req went low");
    end
  endtask

  // Count clk_out edges over whole counter periods
  task automatic measure_windows(input int windows, input logic [31:0] expected);
    int unsigned start;
    int unsigned seen;
    @(negedge clk_in);
    for (int w = 0; w < windows; w++) begin
      start = pulse_cnt;
      repeat (WINDOW) @(negedge clk_in);
      seen = pulse_cnt - start;
      check_value("clk_out pulses per window", seen, expected);
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    void'($urandom(32'h9152));
    rst      = 1'b1;
    trigger  = 1'b0;
    cfg_req  = 1'b0;
    cfg_data = '0;
    load_table();

    repeat (RST_CYCLES) @(posedge clk_in);
    rst <= 1'b0;

    // Out of reset, no ack and every pulse passes
    @(negedge clk_in);
    check_value("cfg_ack", cfg_ack, 32'h0);
    @(posedge clk_in);
    trigger <= 1'b1;
    repeat (SETTLE) @(posedge clk_in);
    measure_windows(4, WINDOW);

    for (int r = 0; r < NUM_ROWS; r++) begin
      // Random idle gap before each write
      gap = $urandom % MAX_GAP;
      repeat (gap) @(posedge clk_in);
      wr_cfg.enable = rows[r].enable;
      wr_cfg.skip   = rows[r].skip;
      write_cfg(wr_cfg);
      @(posedge clk_in);
      trigger <= rows[r].trigger;
      // Covers the synchronizer and the first counter update
      repeat (SETTLE) @(posedge clk_in);
      measure_windows(int'(rows[r].windows), 32'(rows[r].expected));
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/throttle_top.sv
// Clock throttle top level
// Configuration slave feeding the pulse-skipping core

`timescale 1ns/1ps
`default_nettype none

module throttle_top
  import throttle_pkg::*;
(
  // Free-running input clock
  input  logic          clk_in,
  // Synchronous active-high reset
  input  logic          rst,
  // Asynchronous throttle trigger
  input  logic          trigger,
  // Four-phase configuration port
  input  logic          cfg_req,
  input  throttle_cfg_t cfg_data,
  output logic          cfg_ack,
  // Gated output clock
  output logic          clk_out
);

  // Active settings from the register block
  throttle_cfg_t cfg;

  throttle_cfg_regs throttle_cfg_regs_inst (
    .clk_in  (clk_in),
    .rst     (rst),
    .cfg_req (cfg_req),
    .cfg_data(cfg_data),
    .cfg_ack (cfg_ack),
    .cfg     (cfg)
  );

  throttle_core throttle_core_inst (
    .clk_in (clk_in),
    .rst    (rst),
    .trigger(trigger),
    .cfg    (cfg),
    .clk_out(clk_out)
  );

endmodule

`default_nettype wire

// File: design/throttle_cfg_regs.sv
// Throttle configuration registers
// Four-phase req/ack slave that holds the active throttle settings

`timescale 1ns/1ps
`default_nettype none

module throttle_cfg_regs
  import throttle_pkg::*;
(
  input  logic          clk_in,
  input  logic          rst,
  // Master side of the handshake
  input  logic          cfg_req,
  input  throttle_cfg_t cfg_data,
  output logic          cfg_ack,
  // Settings seen by the core
  output throttle_cfg_t cfg
);

  cfg_state_t state;
  logic       accept;

  // New word is taken on the first edge that sees req in idle
  assign accept = (state == throttle_pkg::cfg_idle) && cfg_req;

  // ------------------------------------------------------------
  // Handshake FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state   <= throttle_pkg::cfg_idle;
      cfg_ack <= 1'b0;
    end else begin
      case (state)
        throttle_pkg::cfg_idle: begin
          if (cfg_req) begin
            state   <= throttle_pkg::cfg_ack;
            cfg_ack <= 1'b1;
          end
        end
        // Ack held until the master lets go of req
        throttle_pkg::cfg_ack: begin
          if (!cfg_req) begin
            state   <= throttle_pkg::cfg_wait_low;
            cfg_ack <= 1'b0;
          end
        end
        // One guard cycle with ack low before the next accept
        throttle_pkg::cfg_wait_low: begin
          state <= throttle_pkg::cfg_idle;
        end
        default: begin
          state   <= throttle_pkg::cfg_idle;
          cfg_ack <= 1'b0;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Held settings
  // ------------------------------------------------------------

  // Comes out on the same edge that raises ack
  always_ff @(posedge clk_in) begin
    if (rst) begin
      cfg <= '0;
    end else if (accept) begin
      cfg <= cfg_data;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Ack only answers a request
  ack_needs_req_a: assert property (
    @(posedge clk_in) disable iff (rst)
    $rose(cfg_ack) |-> $past(cfg_req)
  ) else $error("throttle_cfg_regs cfg_ack rose without cfg_req");

  // Master keeps the word steady until it is taken
  data_stable_a: assert property (
    @(posedge clk_in) disable iff (rst)
    (cfg_req && !cfg_ack) |=> (!cfg_req || $stable(cfg_data))
  ) else $error("throttle_cfg_regs cfg_data changed during request");

endmodule

`default_nettype wire

// File: design/throttle_core.sv
// Clock throttle core
// Wrapping skip counter that swallows the first skip pulses of each period

`timescale 1ns/1ps
`default_nettype none

`include "throttle_defs.svh"

module throttle_core
  import throttle_pkg::*;
(
  // Free-running input clock
  input  logic          clk_in,
  // Synchronous active-high reset
  input  logic          rst,
  // Asynchronous throttle trigger
  input  logic          trigger,
  // Held throttle settings
  input  throttle_cfg_t cfg,
  // Gated output clock
  output logic          clk_out
);

  localparam int CNTR_W = `THR_CNTR_WIDTH;
  localparam logic [CNTR_W-1:0] CNTR_ONE = {{(CNTR_W-1){1'b0}}, 1'b1};

  logic              sync_trigger;
  logic [CNTR_W-1:0] cntr;
  logic              cntr_clear;
  logic              gate_en;

  // ------------------------------------------------------------
  // Trigger into clk_in domain
  // ------------------------------------------------------------

  trigger_sync #(
    .STAGES(`THR_SYNC_STAGES)
  ) trigger_sync_inst (
    .clk_in  (clk_in),
    .rst     (rst),
    .async_in(trigger),
    .sync_out(sync_trigger)
  );

  // ------------------------------------------------------------
  // Skip counter
  // ------------------------------------------------------------

  // Counter only runs while throttling is active
  assign cntr_clear = !cfg.enable || !sync_trigger;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      cntr <= '0;
    end else if (cntr_clear) begin
      cntr <= '0;
    end else begin
      // Natural wrap from all ones back to zero
      cntr <= cntr + CNTR_ONE;
    end
  end

  // ------------------------------------------------------------
  // Gate enable
  // ------------------------------------------------------------

  // Pulses pass when throttling is off or trigger is idle
  // Otherwise the first skip counts of each period are swallowed
  assign gate_en = !cfg.enable || !sync_trigger || (cntr >= cfg.skip);

  // Enable is latched in the low phase, so it gates the next high pulse
  clock_gate clock_gate_inst (
    .clk_in (clk_in),
    .rst    (rst),
    .en     (gate_en),
    .clk_out(clk_out)
  );

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Disabled throttling never swallows a pulse
  // Settings from the last low phase decide the high pulse that just ended
  disabled_passes_a: assert property (
    @(negedge clk_in) disable iff (rst)
    !$past(cfg.enable) |-> clk_out
  ) else $error("throttle_core clk_out pulse swallowed with throttling disabled");

  // New period always starts from zero
  clear_to_zero_a: assert property (
    @(posedge clk_in) disable iff (rst)
    cntr_clear |=> (cntr == '0)
  ) else $error("throttle_core counter not zero after clear");

endmodule

`default_nettype wire

// File: design/clock_gate.sv
// Latch-based clock gate with reset
// Passes clk_in while the enable is latched high, always on during reset

`timescale 1ns/1ps
`default_nettype none

module clock_gate (
  input  logic clk_in,
  input  logic rst,
  input  logic en,
  output logic clk_out
);

  // Enable as seen by the AND gate
  logic en_latched;
  // Latched enable sampled at the start of the high phase
  logic en_at_rise;

  // ------------------------------------------------------------
  // Gate
  // ------------------------------------------------------------

  // Transparent while clk_in is low, closed during the high phase
  // Reset forces the enable so the clock keeps running
  always_latch begin
    if (!clk_in) begin
      en_latched <= en | rst;
    end
  end

  assign clk_out = clk_in & en_latched;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  always_ff @(posedge clk_in) begin
    en_at_rise <= en_latched;
  end

  // A change in the high phase would chop the output pulse
  en_stable_high_a: assert property (
    @(negedge clk_in) disable iff (rst)
    en_latched == en_at_rise
  ) else $error("clock_gate enable changed while clk_in was high");

endmodule

`default_nettype wire

// File: design/trigger_sync.sv
// Trigger synchronizer
// Flop chain that brings an asynchronous level into the clk_in domain

`timescale 1ns/1ps
`default_nettype none

module trigger_sync #(
  // Chain depth, at least 2
  parameter int STAGES = 2
) (
  input  logic clk_in,
  input  logic rst,
  input  logic async_in,
  output logic sync_out
);

  // Depth below 2 gives no metastability protection
  initial begin : stages_check
    assert (STAGES >= 2)
      else $fatal(1, "trigger_sync needs STAGES >= 2, got %0d", STAGES);
  end

  // First flop samples the async level, last one feeds the core
  (* ASYNC_REG = "TRUE" *) logic [STAGES-1:0] sync_q;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      sync_q <= '0;
    end else begin
      // Shift toward the MSB
      sync_q <= {sync_q[STAGES-2:0], async_in};
    end
  end

  assign sync_out = sync_q[STAGES-1];

endmodule

`default_nettype wire

// File: design/throttle_pkg.sv
// Clock throttle types
// Configuration word and handshake state encoding

`default_nettype none

`include "throttle_defs.svh"

package throttle_pkg;

  // ------------------------------------------------------------
  // Configuration word
  // ------------------------------------------------------------

  // Enable sits above the skip field
  typedef struct packed {
    // Throttling on
    logic                       enable;
    // Pulses swallowed per counter period
    logic [`THR_CNTR_WIDTH-1:0] skip;
  } throttle_cfg_t;

  // ------------------------------------------------------------
  // Four-phase configuration slave states
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    cfg_idle,
    cfg_ack,
    cfg_wait_low
  } cfg_state_t;

endpackage

`default_nettype wire

// File: design/throttle_defs.svh
// Clock throttle shared parameters
// Skip counter width and trigger synchronizer depth

`ifndef THROTTLE_DEFS_SVH
`define THROTTLE_DEFS_SVH

// ------------------------------------------------------------
// Skip counter
// ------------------------------------------------------------

// Width of the skip counter and of the skip value
// Must be at least 2, counter period is 2**width cycles
`define THR_CNTR_WIDTH 3

// ------------------------------------------------------------
// Trigger synchronizer
// ------------------------------------------------------------

// Number of flops between the async trigger and the core
`define THR_SYNC_STAGES 2

`endif
